//--- sim.f
verilog/soc_periph_pkg.sv
verilog/periph_bus_decoder.sv
verilog/apb_gpio.sv
verilog/apb_timer.sv
verilog/fc_event_router.sv
verilog/soc_peripherals.sv
sim/soc_peripherals_properties.sv
sim/tb_soc_peripherals.sv

//--- Makefile
# Verilator build for the peripheral subsystem testbench

TOP := tb_soc_peripherals

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- sim/tb_soc_peripherals.sv
/* directed tests for the peripheral subsystem with inputs changing on the falling edge
   gpio width fixed at 32 so pins compare as data words
   the first error stops the run */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_peripherals
  import soc_periph_pkg::*;
;

  localparam int N_GPIO = 32;
  localparam int PREADY_TIMEOUT = 4;
  localparam int EVENT_TIMEOUT = 60;
  localparam int POLL_TRIES = 8;
  localparam int REF_WINDOW = 8;
  localparam apb_addr_t GPIO_BASE = 32'h0000_0000;
  localparam apb_addr_t TIMER_BASE = 32'h0000_1000;
  localparam apb_addr_t NONE_BASE = 32'h0000_5000;

  logic              clk;
  logic              rst;
  apb_req_t          apb_req;
  apb_resp_t         apb_resp;
  logic [N_GPIO-1:0] gpio_in;
  logic [N_GPIO-1:0] gpio_out;
  logic [N_GPIO-1:0] gpio_oe;
  logic              stoptimer;
  logic              slow_clk;
  fc_events_t        fc_events;
  logic [31:0]       lfsr_q;
  // register model for readback
  apb_data_t         exp_dir;
  apb_data_t         exp_out;
  apb_data_t         exp_cmp;
  apb_data_t         exp_cfg;

  soc_peripherals #(
    .N_GPIO (N_GPIO)
  ) DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .apb_req_i   (apb_req),
    .apb_resp_o  (apb_resp),
    .gpio_in_i   (gpio_in),
    .gpio_out_o  (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .stoptimer_i (stoptimer),
    .slow_clk_i  (slow_clk),
    .fc_events_o (fc_events)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit taken
  function automatic apb_data_t rand_bits(input int n);
    apb_data_t w;
    logic      fb;
    w = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w = {w[30:0], fb};
    end
    return w;
  endfunction

  function automatic apb_addr_t reg_addr(input apb_addr_t base, input logic [1:0] idx);
    return base | {28'd0, idx, 2'b00};
  endfunction

  task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input apb_resp_t resp);
    if (resp.pslverr !== exp) begin
      stop_with_failure($sformatf("FAIL time=%0t %s.pslverr expected=%b actual=%b",
                                  $time, name, exp, resp.pslverr));
    end
  endtask

  task automatic check_events(input string name, input fc_events_t exp, input fc_events_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                  $time, name, exp, act));
    end
  endtask

  //////////////////////////////
  // apb master
  //////////////////////////////
  // setup then access with the response taken at the edge ending the access
  task automatic apb_transfer(input apb_addr_t addr, input logic write,
                              input apb_data_t wdata, output apb_resp_t resp);
    int waited;
    waited = 0;
    @(negedge clk);
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pwrite  = write;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_resp.pready) begin
      if (waited >= PREADY_TIMEOUT) begin
        stop_with_failure("APB slave never raised pready");
      end
      waited++;
      @(posedge clk);
    end
    resp = apb_resp;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                           output apb_resp_t resp);
    apb_transfer(addr, 1'b1, data, resp);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_resp_t resp);
    apb_transfer(addr, 1'b0, '0, resp);
  endtask

  // reads GPIO_IN until it shows the pins or the tries run out
  task automatic poll_gpio_in(input apb_data_t exp, output apb_data_t rd);
    apb_resp_t resp;
    int        tries;
    tries = 0;
    rd = ~exp;
    while (rd !== exp && tries < POLL_TRIES) begin
      apb_read(reg_addr(GPIO_BASE, GPIO_IN), resp);
      rd = resp.prdata;
      tries++;
    end
  endtask

  task automatic wait_for_event(input int bit_idx, output fc_events_t seen);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!fc_events[bit_idx]) begin
      if (waited >= EVENT_TIMEOUT) begin
        stop_with_failure($sformatf("no pulse on event bit %0d", bit_idx));
      end
      waited++;
      @(negedge clk);
    end
    seen = fc_events;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic test_gpio_regs();
    apb_resp_t resp;
    exp_dir = rand_bits(32);
    exp_out = rand_bits(32);
    apb_write(reg_addr(GPIO_BASE, GPIO_DIR), exp_dir, resp);
    apb_write(reg_addr(GPIO_BASE, GPIO_OUT), exp_out, resp);
    check_data("gpio_oe_o", exp_dir, gpio_oe);
    check_data("gpio_out_o", exp_out, gpio_out);
    apb_read(reg_addr(GPIO_BASE, GPIO_DIR), resp);
    check_data("GPIO_DIR", exp_dir, resp.prdata);
    apb_read(reg_addr(GPIO_BASE, GPIO_OUT), resp);
    check_data("GPIO_OUT", exp_out, resp.prdata);
    // offset outside the register window
    apb_read(GPIO_BASE | 32'h10, resp);
    check_data("GPIO unknown offset", '0, resp.prdata);
    check_err("GPIO unknown offset", 1'b0, resp);
  endtask

  task automatic test_gpio_irq();
    apb_resp_t  resp;
    apb_data_t  din;
    apb_data_t  rd;
    apb_data_t  pick;
    logic [4:0] b;
    fc_events_t exp;
    fc_events_t seen;
    din = rand_bits(32);
    @(negedge clk);
    gpio_in = din;
    poll_gpio_in(din, rd);
    check_data("GPIO_IN", din, rd);
    pick = rand_bits(5);
    b = pick[4:0];
    // low first while interrupts are still off
    din[b] = 1'b0;
    @(negedge clk);
    gpio_in = din;
    poll_gpio_in(din, rd);
    check_data("GPIO_IN", din, rd);
    apb_write(reg_addr(GPIO_BASE, GPIO_INT_EN), apb_data_t'(1) << b, resp);
    din[b] = 1'b1;
    @(negedge clk);
    gpio_in = din;
    wait_for_event(FC_EVT_GPIO, seen);
    exp = '0;
    exp[FC_EVT_GPIO] = 1'b1;
    check_events("fc_events_o", exp, seen);
    apb_write(reg_addr(GPIO_BASE, GPIO_INT_EN), '0, resp);
  endtask

  task automatic test_timer_match();
    apb_resp_t  resp;
    fc_events_t exp;
    fc_events_t seen;
    exp_cmp = 32'd20;
    exp_cfg = 32'd1;
    apb_write(reg_addr(TIMER_BASE, TIMER_CMP), exp_cmp, resp);
    apb_write(reg_addr(TIMER_BASE, TIMER_CFG), exp_cfg, resp);
    wait_for_event(FC_EVT_MTIME, seen);
    exp = '0;
    exp[FC_EVT_MTIME] = 1'b1;
    exp[FC_EVT_TIMER_LO] = 1'b1;
    check_events("fc_events_o", exp, seen);
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    // auto-reload keeps the count within the compare value
    if ($isunknown(resp.prdata) || resp.prdata > exp_cmp) begin
      stop_with_failure($sformatf("FAIL time=%0t TIMER_CNT expected<=%0d actual=%0d",
                                  $time, exp_cmp, resp.prdata));
    end
  endtask

  task automatic test_timer_stop();
    apb_resp_t resp;
    apb_data_t first;
    apb_data_t held;
    @(negedge clk);
    stoptimer = 1'b1;
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    first = resp.prdata;
    repeat (6) @(negedge clk);
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    held = resp.prdata;
    check_data("TIMER_CNT while stopped", first, held);
    @(negedge clk);
    stoptimer = 1'b0;
    repeat (3) @(negedge clk);
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    if (resp.prdata === held) begin
      stop_with_failure("timer count did not move after stoptimer_i was released");
    end
    // quiet timer for the remaining tests
    exp_cfg = '0;
    apb_write(reg_addr(TIMER_BASE, TIMER_CFG), exp_cfg, resp);
  endtask

  task automatic test_ref_clk();
    int pulses;
    for (int t = 0; t < 4; t++) begin
      pulses = 0;
      @(negedge clk);
      slow_clk = ~slow_clk;
      // level held for the whole window
      for (int c = 0; c < REF_WINDOW; c++) begin
        @(negedge clk);
        if (fc_events[FC_EVT_REF_CLK]) pulses++;
      end
      check_data("ref clock edge pulses", apb_data_t'(1), apb_data_t'(pulses));
    end
  endtask

  task automatic test_unmapped();
    apb_resp_t resp;
    apb_data_t cnt_before;
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    cnt_before = resp.prdata;
    apb_read(NONE_BASE, resp);
    check_err("region 5 read", 1'b1, resp);
    check_data("region 5 prdata", '0, resp.prdata);
    // offsets that alias real registers if the decode leaks
    for (int i = 0; i < 3; i++) begin
      apb_write(reg_addr(NONE_BASE, 2'(i)), rand_bits(32), resp);
      check_err("region 5 write", 1'b1, resp);
    end
    apb_read(reg_addr(GPIO_BASE, GPIO_DIR), resp);
    check_data("GPIO_DIR", exp_dir, resp.prdata);
    apb_read(reg_addr(GPIO_BASE, GPIO_OUT), resp);
    check_data("GPIO_OUT", exp_out, resp.prdata);
    apb_read(reg_addr(TIMER_BASE, TIMER_CFG), resp);
    check_data("TIMER_CFG", exp_cfg, resp.prdata);
    apb_read(reg_addr(TIMER_BASE, TIMER_CNT), resp);
    check_data("TIMER_CNT", cnt_before, resp.prdata);
    apb_read(reg_addr(TIMER_BASE, TIMER_CMP), resp);
    check_data("TIMER_CMP", exp_cmp, resp.prdata);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    lfsr_q = 32'h09a26d4c;
    rst = 1'b1;
    apb_req = '0;
    gpio_in = '0;
    stoptimer = 1'b0;
    slow_clk = 1'b0;
    exp_dir = '0;
    exp_out = '0;
    exp_cmp = '1;
    exp_cfg = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_gpio_regs();
    test_gpio_irq();
    test_timer_match();
    test_timer_stop();
    test_ref_clk();
    test_unmapped();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/soc_peripherals_properties.sv
/* bus and event rules checked on the subsystem top, bound by module name
   assumes a single clk_i domain and the synchronous reset on rst_i */
`timescale 1ns/1ps
`default_nettype none

module soc_peripherals_properties
  import soc_periph_pkg::*;
#(
  parameter int N_GPIO = 32
) (
  input wire logic              clk_i,
  input wire logic              rst_i,
  input wire apb_resp_t         resp_i,
  input wire apb_req_t          gpio_req_i,
  input wire apb_req_t          timer_req_i,
  input wire fc_events_t        events_i,
  input wire logic [N_GPIO-1:0] gpio_oe_i
);

  // error only on a completing transfer
  a_err_needs_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_i.pslverr |-> resp_i.pready)
    else $error("pslverr high without pready");

  // one slave at a time
  a_one_psel: assert property (@(posedge clk_i) disable iff (rst_i)
    !(gpio_req_i.psel && timer_req_i.psel))
    else $error("both slaves selected");

  // timer match drives both event lines
  a_timer_evt_pair: assert property (@(posedge clk_i) disable iff (rst_i)
    events_i[FC_EVT_MTIME] == events_i[FC_EVT_TIMER_LO])
    else $error("timer event bits differ");

  // pins stay inputs right after reset
  a_oe_after_reset: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (gpio_oe_i == '0))
    else $error("gpio_oe_o not zero after reset");

endmodule

bind soc_peripherals soc_peripherals_properties #(
  .N_GPIO (N_GPIO)
) i_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .resp_i      (apb_resp_o),
  .gpio_req_i  (gpio_req),
  .timer_req_i (timer_req),
  .events_i    (fc_events_o),
  .gpio_oe_i   (gpio_oe_o)
);

`default_nettype wire

//--- verilog/soc_peripherals.sv
/* peripheral subsystem top, single clock domain on clk_i
   gpio at region 0, timer at region 1, other regions answer with an error */
`timescale 1ns/1ps
`default_nettype none

module soc_peripherals
  import soc_periph_pkg::*;
#(
  parameter int N_GPIO = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  apb_req_t          apb_req_i,
  output apb_resp_t         apb_resp_o,
  input  logic [N_GPIO-1:0] gpio_in_i,
  output logic [N_GPIO-1:0] gpio_out_o,
  output logic [N_GPIO-1:0] gpio_oe_o,
  input  logic              stoptimer_i,
  input  logic              slow_clk_i,
  output fc_events_t        fc_events_o
);

  apb_req_t  gpio_req;
  apb_resp_t gpio_resp;
  apb_req_t  timer_req;
  apb_resp_t timer_resp;
  logic      gpio_irq;
  logic      timer_irq;

  //////////////////////////////
  // bus
  //////////////////////////////
  periph_bus_decoder i_bus (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (apb_req_i),
    .resp_o       (apb_resp_o),
    .gpio_req_o   (gpio_req),
    .gpio_resp_i  (gpio_resp),
    .timer_req_o  (timer_req),
    .timer_resp_i (timer_resp)
  );

  //////////////////////////////
  // peripherals
  //////////////////////////////
  apb_gpio #(
    .N_GPIO (N_GPIO)
  ) i_gpio (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (gpio_req),
    .resp_o     (gpio_resp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (gpio_irq)
  );

  apb_timer i_timer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (timer_req),
    .resp_o      (timer_resp),
    .stoptimer_i (stoptimer_i),
    .irq_o       (timer_irq)
  );

  // events to the fabric controller
  fc_event_router i_events (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .slow_clk_i  (slow_clk_i),
    .timer_irq_i (timer_irq),
    .gpio_irq_i  (gpio_irq),
    .fc_events_o (fc_events_o)
  );

endmodule

`default_nettype wire

//--- verilog/fc_event_router.sv
/* fixed map of peripheral events onto the fc event vector, one cycle late
   slow_clk_i is treated as data, each level must last a few clk_i cycles */
`timescale 1ns/1ps
`default_nettype none

module fc_event_router
  import soc_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       slow_clk_i,
  input  logic       timer_irq_i,
  input  logic       gpio_irq_i,
  output fc_events_t fc_events_o
);

  logic [2:0] ref_q;
  logic       ref_edge;
  fc_events_t events_d;
  fc_events_t events_q;

  // two synchronizer stages plus one for edge compare
  always_ff @(posedge clk_i) begin
    if (rst_i) ref_q <= '0;
    else       ref_q <= {ref_q[1:0], slow_clk_i};
  end

  // rise or fall
  assign ref_edge = ref_q[1] ^ ref_q[2];

  always_comb begin
    events_d                  = '0;
    events_d[FC_EVT_MTIME]    = timer_irq_i;
    events_d[FC_EVT_TIMER_LO] = timer_irq_i;
    events_d[FC_EVT_GPIO]     = gpio_irq_i;
    events_d[FC_EVT_REF_CLK]  = ref_edge;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) events_q <= '0;
    else       events_q <= events_d;
  end

  assign fc_events_o = events_q;

endmodule

`default_nettype wire

//--- verilog/apb_timer.sv
/* 32 bit compare timer with auto-reload to 0 on match
   offset 3 and paddr[11:4] nonzero read 0, compare resets to all ones */
`timescale 1ns/1ps
`default_nettype none

module apb_timer
  import soc_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  apb_req_t  req_i,
  output apb_resp_t resp_o,
  input  logic      stoptimer_i,
  output logic      irq_o
);

  logic       en_q;
  apb_data_t  cnt_q;
  apb_data_t  cmp_q;
  logic       irq_q;
  logic       access;
  logic       wr;
  logic       hit;
  logic       run;
  logic       match;
  timer_reg_e reg_sel;

  assign access  = req_i.psel & req_i.penable;
  assign hit     = (req_i.paddr[11:4] == '0);
  assign wr      = access & req_i.pwrite & hit;
  assign reg_sel = timer_reg_e'(req_i.paddr[3:2]);

  // counting only while enabled and not frozen
  assign run   = en_q & ~stoptimer_i;
  assign match = (cnt_q == cmp_q);

  //////////////////////////////
  // config and compare
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q  <= 1'b0;
      cmp_q <= '1;
    end else if (wr) begin
      if (reg_sel == TIMER_CFG) en_q  <= req_i.pwdata[0];
      if (reg_sel == TIMER_CMP) cmp_q <= req_i.pwdata;
    end
  end

  // counter, software write wins over counting
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      irq_q <= 1'b0;
    end else begin
      irq_q <= run & match;
      if (wr && reg_sel == TIMER_CNT) begin
        cnt_q <= req_i.pwdata;
      end else if (run) begin
        cnt_q <= match ? '0 : cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    resp_o = '0;
    resp_o.pready = access;
    if (hit) begin
      case (reg_sel)
        TIMER_CFG: resp_o.prdata = {31'd0, en_q};
        TIMER_CNT: resp_o.prdata = cnt_q;
        TIMER_CMP: resp_o.prdata = cmp_q;
        default:   resp_o.prdata = '0;
      endcase
    end
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

//--- verilog/apb_gpio.sv
/* zero-wait APB GPIO, N_GPIO from 1 to 32, unused data bits read 0
   offsets with paddr[11:4] nonzero read 0 and drop writes */
`timescale 1ns/1ps
`default_nettype none

module apb_gpio
  import soc_periph_pkg::*;
#(
  parameter int N_GPIO = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  apb_req_t          req_i,
  output apb_resp_t         resp_o,
  input  logic [N_GPIO-1:0] gpio_in_i,
  output logic [N_GPIO-1:0] gpio_out_o,
  output logic [N_GPIO-1:0] gpio_oe_o,
  output logic              irq_o
);

  logic [N_GPIO-1:0] dir_q;
  logic [N_GPIO-1:0] out_q;
  logic [N_GPIO-1:0] int_en_q;
  logic [N_GPIO-1:0] sync1_q;
  logic [N_GPIO-1:0] sync2_q;
  logic [N_GPIO-1:0] prev_q;
  logic              irq_q;
  logic              access;
  logic              hit;
  gpio_reg_e         reg_sel;

  assign access  = req_i.psel & req_i.penable;
  assign hit     = (req_i.paddr[11:4] == '0);
  assign reg_sel = gpio_reg_e'(req_i.paddr[3:2]);

  //////////////////////////////
  // registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      int_en_q <= '0;
    end else if (access && req_i.pwrite && hit) begin
      case (reg_sel)
        GPIO_DIR:    dir_q    <= req_i.pwdata[N_GPIO-1:0];
        GPIO_OUT:    out_q    <= req_i.pwdata[N_GPIO-1:0];
        GPIO_INT_EN: int_en_q <= req_i.pwdata[N_GPIO-1:0];
        default:     ;  // input register is read only
      endcase
    end
  end

  // two stage pin synchronizer, third stage for edge detect
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in_i;
    sync2_q <= sync1_q;
    prev_q  <= sync2_q;
  end

  // rising edge on any enabled pin
  always_ff @(posedge clk_i) begin
    if (rst_i) irq_q <= 1'b0;
    else       irq_q <= |(sync2_q & ~prev_q & int_en_q);
  end

  // read mux, combinational in the access cycle
  always_comb begin
    resp_o = '0;
    resp_o.pready = access;
    if (hit) begin
      case (reg_sel)
        GPIO_DIR:    resp_o.prdata[N_GPIO-1:0] = dir_q;
        GPIO_OUT:    resp_o.prdata[N_GPIO-1:0] = out_q;
        GPIO_IN:     resp_o.prdata[N_GPIO-1:0] = sync2_q;
        GPIO_INT_EN: resp_o.prdata[N_GPIO-1:0] = int_en_q;
        default:     ;
      endcase
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;
  assign irq_o      = irq_q;

endmodule

`default_nettype wire

//--- verilog/periph_bus_decoder.sv
/* one APB master to two zero-wait slaves, region in paddr[15:12]
   unmapped regions complete with pslverr and zero read data */
`timescale 1ns/1ps
`default_nettype none

module periph_bus_decoder
  import soc_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  apb_req_t  req_i,
  output apb_resp_t resp_o,
  output apb_req_t  gpio_req_o,
  input  apb_resp_t gpio_resp_i,
  output apb_req_t  timer_req_o,
  input  apb_resp_t timer_resp_i
);

  periph_sel_e sel;
  logic        err_q;
  logic        access;

  // region decode
  always_comb begin
    case (req_i.paddr[15:12])
      4'd0:    sel = SEL_GPIO;
      4'd1:    sel = SEL_TIMER;
      default: sel = SEL_NONE;
    endcase
  end

  assign access = req_i.psel & req_i.penable;

  // per slave psel, rest of the request passes as is
  always_comb begin
    gpio_req_o       = req_i;
    gpio_req_o.psel  = req_i.psel & (sel == SEL_GPIO);
    timer_req_o      = req_i;
    timer_req_o.psel = req_i.psel & (sel == SEL_TIMER);
  end

  // decode error latched in setup, held through the access cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else if (req_i.psel && !req_i.penable) begin
      err_q <= (sel == SEL_NONE);
    end else if (access) begin
      err_q <= 1'b0;
    end
  end

  // response mux
  always_comb begin
    case (sel)
      SEL_GPIO:  resp_o = gpio_resp_i;
      SEL_TIMER: resp_o = timer_resp_i;
      default: begin
        resp_o.prdata  = '0;
        resp_o.pready  = access;
        resp_o.pslverr = access & err_q;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/soc_periph_pkg.sv
/* shared types for the peripheral subsystem
   APB request and response as packed structs, register maps and event bits */
`default_nettype none

package soc_periph_pkg;

  //////////////////////////////
  // apb bus
  //////////////////////////////
  localparam int APB_ADDR_W = 32;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // master to slave, 67 bits
  typedef struct packed {
    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;
  } apb_req_t;

  // slave to master, 34 bits
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_resp_t;

  //////////////////////////////
  // address map
  //////////////////////////////
  // region from paddr[15:12]
  typedef enum logic [1:0] {
    SEL_GPIO  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_NONE  = 2'd2
  } periph_sel_e;

  // word offsets, paddr[3:2]
  typedef enum logic [1:0] {
    GPIO_DIR    = 2'd0,
    GPIO_OUT    = 2'd1,
    GPIO_IN     = 2'd2,
    GPIO_INT_EN = 2'd3
  } gpio_reg_e;

  typedef enum logic [1:0] {
    TIMER_CFG = 2'd0,
    TIMER_CNT = 2'd1,
    TIMER_CMP = 2'd2
  } timer_reg_e;

  //////////////////////////////
  // fc event vector
  //////////////////////////////
  typedef logic [31:0] fc_events_t;

  localparam int FC_EVT_MTIME    = 7;
  localparam int FC_EVT_TIMER_LO = 16;
  localparam int FC_EVT_GPIO     = 18;
  localparam int FC_EVT_REF_CLK  = 23;

endpackage

`default_nettype wire
